//--- common/uart_settings.svh
// UART build settings
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// entries in each queue
`define UART_FIFO_DEPTH 8

// baud divisor in clock cycles per bit
`define UART_DIV_WIDTH 16
`define UART_DIV_RESET 16'd16
`define UART_DIV_MIN   16'd4      // lower writes are clamped up to this

// APB register offsets
`define UART_ADDR_DATA   4'h0
`define UART_ADDR_STATUS 4'h4
`define UART_ADDR_DIV    4'h8

`endif

//--- common/uart_pkg.sv
// UART line-side types
`default_nettype none

package uart_pkg;

    // counter control issued by the receive FSM
    typedef enum logic [1:0] {
        cnt_zero  = 2'b00,
        cnt_hold  = 2'b01,
        cnt_count = 2'b11
    } cnt_sel_t;

    // one received frame as queued for the CPU
    typedef struct packed {
        logic [7:0] data;
        logic       frame_error;    // stop bit sampled low
    } rx_entry_t;

    // STATUS register layout with tx_full at bit 0
    typedef struct packed {
        logic frame_error;          // sticky until written with 1
        logic rx_overrun;           // sticky until written with 1
        logic rx_empty;
        logic tx_busy;
        logic tx_empty;
        logic tx_full;
    } uart_status_t;

endpackage

`default_nettype wire

//--- common/apb_pkg.sv
// APB port types
`default_nettype none
`include "uart_settings.svh"

package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // mapped register offsets
    typedef enum logic [3:0] {
        addr_data   = `UART_ADDR_DATA,
        addr_status = `UART_ADDR_STATUS,
        addr_div    = `UART_ADDR_DIV
    } apb_addr_t;

endpackage

`default_nettype wire

//--- source/sync_fifo.sv
// synchronous FIFO
`default_nettype none
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  wire logic     clk,
    input  wire logic     reset_b,
    input  wire logic     push,
    input  wire payload_t wdata,
    output logic          full,
    input  wire logic     pop,
    output payload_t      rdata,
    output logic          empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t                   mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = (count == DEPTH);
    assign empty   = (count == 0);
    assign rdata   = mem[rd_ptr];           // head is visible without a pop

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

    // writers and readers honour full and empty on their side
    assert property (@(posedge clk) disable iff (!reset_b) !(push && full))
        else $error("sync_fifo: push while full");
    assert property (@(posedge clk) disable iff (!reset_b) !(pop && empty))
        else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

//--- uart_tx/uart_tx.sv
// UART transmitter
`default_nettype none
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx (
    input  wire logic                       clk,
    input  wire logic                       reset_b,
    input  wire logic [`UART_DIV_WIDTH-1:0] divisor,
    input  wire logic [7:0]                 data,
    input  wire logic                       data_valid,
    output logic                            pop,
    output logic                            tx,
    output logic                            busy
);

    typedef enum logic {
        tx_idle,
        tx_send
    } tx_state_t;

    tx_state_t                  state;
    logic [`UART_DIV_WIDTH-1:0] div_q;       // divisor held for the whole frame
    logic [`UART_DIV_WIDTH-1:0] baud_cnt;
    logic [3:0]                 bit_cnt;
    logic [9:0]                 frame;       // stop, data, start
    logic                       bit_end;
    logic                       frame_end;

    assign bit_end   = (baud_cnt == div_q - 1'b1);
    assign frame_end = (state == tx_send) && bit_end && (bit_cnt == 4'd9);
    // a waiting byte is taken at the end of the stop bit, so frames run back to back
    assign pop       = data_valid && ((state == tx_idle) || frame_end);
    assign busy      = (state == tx_send);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state    <= tx_idle;
            div_q    <= `UART_DIV_RESET;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;           // line idles high
        end else begin
            tx <= (state == tx_send) ? frame[0] : 1'b1;
            if (pop) begin
                state    <= tx_send;
                div_q    <= divisor;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end else if (frame_end) begin
                state <= tx_idle;
            end else if (state == tx_send) begin
                if (bit_end) begin
                    baud_cnt <= '0;
                    bit_cnt  <= bit_cnt + 1'b1;
                end else begin
                    baud_cnt <= baud_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            frame <= {1'b1, data, 1'b0};
        else if (state == tx_send && bit_end)
            frame <= {1'b1, frame[9:1]};
    end

    // the registered line output must have settled to idle by the time busy drops
    assert property (@(posedge clk) disable iff (!reset_b) !busy |-> tx)
        else $error("uart_tx: line low while not busy");

endmodule

`default_nettype wire

//--- uart_rx/uart_rx_controller.sv
// UART receive controller
`default_nettype none
`timescale 1ns/1ps

module uart_rx_controller (
    input  wire logic         clk,
    input  wire logic         reset_b,
    input  wire logic         rx,
    input  wire logic         mid_reached,
    input  wire logic         last_bit,
    output uart_pkg::cnt_sel_t baud_sel,
    output uart_pkg::cnt_sel_t bit_sel,
    output logic              shift_en,
    output logic              half_sel,
    output logic              stop_sample,
    output logic              data_ready
);

    typedef enum logic [2:0] {
        st_idle,        // wait for a falling edge on the line
        st_first_half,  // count to the middle of data bit 0
        st_shift,       // take one data bit
        st_check,       // all eight bits in?
        st_next_bit,    // count to the middle of the next data bit
        st_stop,        // count to the middle of the stop bit
        st_ready        // hand the entry to the queue
    } rx_state_t;

    rx_state_t state;
    rx_state_t next_state;
    logic      rx_meta;
    logic      rx_sync;
    logic      rx_prev;

    // same two-flop depth as the datapath, so the edge lines up with its samples
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state   <= st_idle;
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            state   <= next_state;
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_comb begin
        next_state  = state;
        baud_sel    = uart_pkg::cnt_hold;
        bit_sel     = uart_pkg::cnt_hold;
        shift_en    = 1'b0;
        half_sel    = 1'b0;
        stop_sample = 1'b0;
        data_ready  = 1'b0;
        case (state)
            st_idle: begin
                baud_sel = uart_pkg::cnt_zero;
                bit_sel  = uart_pkg::cnt_zero;
                half_sel = 1'b1;
                if (rx_prev && !rx_sync)            // start bit edge
                    next_state = st_first_half;
            end
            st_first_half: begin
                baud_sel = uart_pkg::cnt_count;
                bit_sel  = uart_pkg::cnt_zero;
                half_sel = 1'b1;                    // 1.5 bit times
                if (mid_reached)
                    next_state = st_shift;
            end
            st_shift: begin
                shift_en   = 1'b1;
                baud_sel   = uart_pkg::cnt_zero;
                bit_sel    = uart_pkg::cnt_count;
                next_state = st_check;
            end
            st_check: begin
                next_state = last_bit ? st_stop : st_next_bit;
            end
            st_next_bit: begin
                baud_sel = uart_pkg::cnt_count;
                if (mid_reached)
                    next_state = st_shift;
            end
            st_stop: begin
                baud_sel = uart_pkg::cnt_count;
                if (mid_reached) begin
                    stop_sample = 1'b1;
                    next_state  = st_ready;
                end
            end
            st_ready: begin
                baud_sel   = uart_pkg::cnt_zero;
                bit_sel    = uart_pkg::cnt_zero;
                data_ready = 1'b1;
                next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    assert property (@(posedge clk) disable iff (!reset_b) !(shift_en && data_ready))
        else $error("uart_rx_controller: shift and data_ready together");

endmodule

`default_nettype wire

//--- uart_rx/uart_rx_datapath.sv
// UART receive datapath
`default_nettype none
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx_datapath (
    input  wire logic                       clk,
    input  wire logic                       reset_b,
    input  wire logic                       rx,
    input  wire logic [`UART_DIV_WIDTH-1:0] divisor,
    input  wire uart_pkg::cnt_sel_t         baud_sel,
    input  wire uart_pkg::cnt_sel_t         bit_sel,
    input  wire logic                       shift_en,
    input  wire logic                       half_sel,
    input  wire logic                       stop_sample,
    input  wire logic                       data_ready,
    output logic                            mid_reached,
    output logic                            last_bit,
    output uart_pkg::rx_entry_t             entry,
    output logic                            entry_valid
);

    localparam int CW = `UART_DIV_WIDTH + 1;

    logic                       rx_meta;
    logic                       rx_sync;
    logic [`UART_DIV_WIDTH-1:0] div_q;
    logic [CW-1:0]              baud_cnt;
    logic [CW-1:0]              compare_val;
    logic [3:0]                 bit_cnt;
    logic [7:0]                 shift_reg;
    logic                       stop_bit;

    // bit times less the FSM cycles spent between two samples
    assign compare_val = half_sel ? CW'(div_q) + CW'(div_q >> 1) - CW'(2)
                                  : CW'(div_q) - CW'(3);
    assign mid_reached = (baud_cnt == compare_val);
    assign last_bit    = (bit_cnt == 4'd8);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            div_q    <= `UART_DIV_RESET;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            case (baud_sel)
                uart_pkg::cnt_zero:  baud_cnt <= '0;
                uart_pkg::cnt_count: baud_cnt <= baud_cnt + 1'b1;
                default:             baud_cnt <= baud_cnt;
            endcase
            case (bit_sel)
                uart_pkg::cnt_zero:  bit_cnt <= '0;
                uart_pkg::cnt_count: bit_cnt <= bit_cnt + 1'b1;
                default:             bit_cnt <= bit_cnt;
            endcase
            // pick up a new divisor only between frames
            if (baud_sel == uart_pkg::cnt_zero && bit_sel == uart_pkg::cnt_zero)
                div_q <= divisor;
        end
    end

    always_ff @(posedge clk) begin
        if (shift_en)
            shift_reg <= {rx_sync, shift_reg[7:1]};   // lsb arrives first
        if (stop_sample)
            stop_bit <= rx_sync;
    end

    assign entry.data        = shift_reg;
    assign entry.frame_error = !stop_bit;
    assign entry_valid       = data_ready;

endmodule

`default_nettype wire

//--- source/uart_apb_regs.sv
// UART APB registers
`default_nettype none
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_apb_regs (
    input  wire logic                 clk,
    input  wire logic                 reset_b,
    input  wire apb_pkg::apb_req_t    req,
    output apb_pkg::apb_rsp_t         rsp,
    output logic                      tx_push,
    output logic [7:0]                tx_wdata,
    input  wire logic                 tx_full,
    input  wire logic                 tx_empty,
    input  wire logic                 tx_busy,
    output logic                      rx_pop,
    input  wire uart_pkg::rx_entry_t  rx_entry,
    input  wire logic                 rx_empty,
    input  wire logic                 rx_drop,
    output logic [`UART_DIV_WIDTH-1:0] divisor
);

    logic                       access;     // access phase of a transfer
    logic                       addr_hit;
    logic                       wr_data;
    logic                       rd_data;
    logic                       wr_status;
    logic                       wr_div;
    logic                       rx_overrun;
    logic                       frame_error;
    logic [`UART_DIV_WIDTH-1:0] new_div;
    uart_pkg::uart_status_t     status;
    uart_pkg::uart_status_t     clear_mask;

    assign access    = req.psel && req.penable;
    assign addr_hit  = req.paddr inside {apb_pkg::addr_data, apb_pkg::addr_status,
                                         apb_pkg::addr_div};
    assign wr_data   = access && req.pwrite && (req.paddr == apb_pkg::addr_data);
    assign rd_data   = access && !req.pwrite && (req.paddr == apb_pkg::addr_data);
    assign wr_status = access && req.pwrite && (req.paddr == apb_pkg::addr_status);
    assign wr_div    = access && req.pwrite && (req.paddr == apb_pkg::addr_div);

    assign tx_push  = wr_data && !tx_full;  // dropped when the queue is full
    assign tx_wdata = req.pwdata[7:0];
    assign rx_pop   = rd_data && !rx_empty;

    assign clear_mask = uart_pkg::uart_status_t'(req.pwdata[$bits(uart_pkg::uart_status_t)-1:0]);
    assign new_div    = (req.pwdata[`UART_DIV_WIDTH-1:0] < `UART_DIV_MIN) ?
                        `UART_DIV_MIN : req.pwdata[`UART_DIV_WIDTH-1:0];

    always_comb begin
        status.frame_error = frame_error;
        status.rx_overrun  = rx_overrun;
        status.rx_empty    = rx_empty;
        status.tx_busy     = tx_busy;
        status.tx_empty    = tx_empty;
        status.tx_full     = tx_full;
    end

    always_comb begin
        rsp.pready  = 1'b1;                 // no wait states
        rsp.pslverr = access && (!addr_hit || (wr_data && tx_full) || (rd_data && rx_empty));
        rsp.prdata  = '0;
        case (req.paddr)
            apb_pkg::addr_data:   rsp.prdata[7:0] = rx_entry.data;
            apb_pkg::addr_status: rsp.prdata[$bits(status)-1:0] = status;
            apb_pkg::addr_div:    rsp.prdata[`UART_DIV_WIDTH-1:0] = divisor;
            default:              rsp.prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            divisor     <= `UART_DIV_RESET;
            rx_overrun  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            if (wr_div)
                divisor <= new_div;
            // a new event wins over a clear in the same cycle
            if (rx_drop)
                rx_overrun <= 1'b1;
            else if (wr_status && clear_mask.rx_overrun)
                rx_overrun <= 1'b0;
            if (rx_pop && rx_entry.frame_error)
                frame_error <= 1'b1;
            else if (wr_status && clear_mask.frame_error)
                frame_error <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_top.sv
// UART peripheral top
`default_nettype none
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_top (
    input  wire logic              clk,
    input  wire logic              reset_b,
    input  wire apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t      apb_rsp,
    output logic                   tx,
    input  wire logic              rx
);

    logic                       tx_push;
    logic [7:0]                 tx_wdata;
    logic                       tx_full;
    logic                       tx_empty;
    logic                       tx_busy;
    logic                       tx_pop;
    logic [7:0]                 tx_data;
    logic                       tx_valid;
    logic                       rx_pop;
    logic                       rx_full;
    logic                       rx_empty;
    logic                       rx_push;
    logic                       rx_drop;
    uart_pkg::rx_entry_t        rx_head;
    uart_pkg::rx_entry_t        rx_entry;
    logic                       rx_entry_valid;
    logic [`UART_DIV_WIDTH-1:0] divisor;
    uart_pkg::cnt_sel_t         baud_sel;
    uart_pkg::cnt_sel_t         bit_sel;
    logic                       shift_en;
    logic                       half_sel;
    logic                       stop_sample;
    logic                       data_ready;
    logic                       mid_reached;
    logic                       last_bit;

    assign tx_valid = !tx_empty;
    assign rx_push  = rx_entry_valid && !rx_full;
    assign rx_drop  = rx_entry_valid && rx_full;     // frame lost on a full queue

    uart_apb_regs uart_apb_regs_inst (
        .clk(clk), .reset_b(reset_b), .req(apb_req), .rsp(apb_rsp),
        .tx_push(tx_push), .tx_wdata(tx_wdata), .tx_full(tx_full),
        .tx_empty(tx_empty), .tx_busy(tx_busy), .rx_pop(rx_pop),
        .rx_entry(rx_head), .rx_empty(rx_empty), .rx_drop(rx_drop),
        .divisor(divisor)
    );

    sync_fifo #(.payload_t(logic [7:0]), .DEPTH(`UART_FIFO_DEPTH)) tx_fifo_inst (
        .clk(clk), .reset_b(reset_b), .push(tx_push), .wdata(tx_wdata), .full(tx_full),
        .pop(tx_pop), .rdata(tx_data), .empty(tx_empty)
    );

    sync_fifo #(.payload_t(uart_pkg::rx_entry_t), .DEPTH(`UART_FIFO_DEPTH)) rx_fifo_inst (
        .clk(clk), .reset_b(reset_b), .push(rx_push), .wdata(rx_entry), .full(rx_full),
        .pop(rx_pop), .rdata(rx_head), .empty(rx_empty)
    );

    uart_tx uart_tx_inst (
        .clk(clk), .reset_b(reset_b), .divisor(divisor), .data(tx_data),
        .data_valid(tx_valid), .pop(tx_pop), .tx(tx), .busy(tx_busy)
    );

    uart_rx_controller uart_rx_controller_inst (
        .clk(clk), .reset_b(reset_b), .rx(rx), .mid_reached(mid_reached),
        .last_bit(last_bit), .baud_sel(baud_sel), .bit_sel(bit_sel), .shift_en(shift_en),
        .half_sel(half_sel), .stop_sample(stop_sample), .data_ready(data_ready)
    );

    uart_rx_datapath uart_rx_datapath_inst (
        .clk(clk), .reset_b(reset_b), .rx(rx), .divisor(divisor), .baud_sel(baud_sel),
        .bit_sel(bit_sel), .shift_en(shift_en), .half_sel(half_sel),
        .stop_sample(stop_sample), .data_ready(data_ready), .mid_reached(mid_reached),
        .last_bit(last_bit), .entry(rx_entry), .entry_valid(rx_entry_valid)
    );

endmodule

`default_nettype wire

//--- sim/uart_tb_tasks.svh
// UART testbench tasks
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// queue entry expected for a byte sent with the given stop-bit level
function automatic uart_pkg::rx_entry_t expected_entry(input logic [7:0] data,
                                                       input logic       stop_bit);
    uart_pkg::rx_entry_t e;
    e.data        = data;
    e.frame_error = ~stop_bit;              // a low stop bit is a framing error
    return e;
endfunction

// one APB transfer with the response taken in the middle of the access cycle
task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    apb_pkg::apb_req_t r;
    r         = '0;
    r.psel    = 1'b1;
    r.pwrite  = write;
    r.paddr   = addr;
    r.pwdata  = wdata;
    @(posedge clk);
    apb_req <= r;                           // setup cycle
    @(posedge clk);
    apb_req.penable <= 1'b1;                // access cycle
    @(negedge clk);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    if (apb_rsp.pready !== 1'b1) begin
        errors++;
        $display("pready was not high in the access cycle of offset %h", addr);
    end
    @(posedge clk);
    apb_req <= '0;
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, wdata, rdata, slverr);
    if (slverr) begin
        errors++;
        $display("APB write to offset %h was refused with pslverr", addr);
    end
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata);
    logic slverr;
    apb_access(1'b0, addr, 32'h0, rdata, slverr);
    if (slverr) begin
        errors++;
        $display("APB read of offset %h was refused with pslverr", addr);
    end
endtask

// serial frame on the rx line with lsb first and one idle bit time after it
task automatic drive_frame(input logic [7:0] data, input logic stop_bit, input int div);
    logic [9:0] bits;
    int         i;
    bits = {stop_bit, data, 1'b0};
    for (i = 0; i < 10; i++) begin
        @(posedge clk);
        drv_rx <= bits[i];
        repeat (div - 1) @(posedge clk);
    end
    @(posedge clk);
    drv_rx <= 1'b1;
    repeat (div - 1) @(posedge clk);
endtask

task automatic compare_entry(input string name, input uart_pkg::rx_entry_t exp,
                             input uart_pkg::rx_entry_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("** Error: %s expected data %h frame_error %b, actual data %h frame_error %b",
                 name, exp.data, exp.frame_error, act.data, act.frame_error);
    end
endtask

task automatic compare_status(input string name, input uart_pkg::uart_status_t exp,
                              input uart_pkg::uart_status_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("** Error: %s expected status %b, actual status %b", name, exp, act);
    end
endtask

task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("** Error: %s expected %h, actual %h", name, exp, act);
    end
endtask

`endif

//--- sim/uart_tb.sv
// UART testbench
`default_nettype none
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tb;

    localparam int num_frames  = 30;        // 16 + 4 + 1 + 9 frames over all tests
    localparam int watchdog_ns = num_frames * 12 * `UART_DIV_RESET * 4 + 20000;

    logic                clk;
    logic                reset_b;
    apb_pkg::apb_req_t   apb_req;
    apb_pkg::apb_rsp_t   apb_rsp;
    logic                tx_line;
    wire logic           rx_line;
    logic                drv_rx;
    logic                loopback;
    integer              seed;
    int                  errors;
    int                  checks;
    int                  tests_run;
    int                  tests_failed;
    int                  test_start_errors;
    int                  cur_div;
    int                  entry_idx;
    uart_pkg::rx_entry_t exp_q[$];
    uart_pkg::rx_entry_t got_q[$];
    event                got_ev;

    assign rx_line = loopback ? tx_line : drv_rx;

    uart_top uart_top_inst (
        .clk(clk), .reset_b(reset_b), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .tx(tx_line), .rx(rx_line)
    );

    always #2 clk = ~clk;

    `include "uart_tb_tasks.svh"

    task automatic read_status(output uart_pkg::uart_status_t st);
        logic [31:0] rd;
        apb_read(`UART_ADDR_STATUS, rd);
        st = uart_pkg::uart_status_t'(rd[$bits(uart_pkg::uart_status_t)-1:0]);
    endtask

    // poll STATUS until the masked bits reach the wanted level
    task automatic poll_status(input string what, input uart_pkg::uart_status_t mask,
                               input logic value);
        uart_pkg::uart_status_t st;
        int                     polls;
        polls = 0;
        do begin
            read_status(st);
            polls++;
        end while (((|(st & mask)) != value) && polls < 16 * cur_div);
        if ((|(st & mask)) != value) begin
            errors++;
            $display("timed out waiting for %s", what);
        end
    endtask

    // byte from DATA, frame status from the sticky flag right after the pop
    task automatic collect_entry();
        uart_pkg::uart_status_t mask;
        uart_pkg::uart_status_t st;
        uart_pkg::rx_entry_t    e;
        logic [31:0]            rd;
        mask          = '0;
        mask.rx_empty = 1'b1;
        poll_status("a received entry", mask, 1'b0);
        apb_read(`UART_ADDR_DATA, rd);
        read_status(st);
        e.data        = rd[7:0];
        e.frame_error = st.frame_error;
        got_q.push_back(e);
        -> got_ev;
    endtask

    task automatic loop_bytes(input int count);
        logic [7:0] b;
        int         i;
        for (i = 0; i < count; i++) begin
            b = $random(seed);
            exp_q.push_back(expected_entry(b, 1'b1));
            apb_write(`UART_ADDR_DATA, {24'h0, b});
        end
        for (i = 0; i < count; i++)
            collect_entry();
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
        end
    endtask

    initial begin : entry_checker
        uart_pkg::rx_entry_t exp_e;
        uart_pkg::rx_entry_t got_e;
        forever begin
            @(got_ev);
            while (got_q.size() != 0) begin
                got_e = got_q.pop_front();
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("received entry %0d was never sent", entry_idx);
                end else begin
                    exp_e = exp_q.pop_front();
                    compare_entry($sformatf("entry %0d", entry_idx), exp_e, got_e);
                end
                entry_idx++;
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the test sequence did not finish", watchdog_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : test_flow
        uart_pkg::uart_status_t exp_st;
        uart_pkg::uart_status_t act_st;
        uart_pkg::uart_status_t mask;
        logic [31:0]            rd;
        logic                   slverr;
        logic [7:0]             sent [`UART_FIFO_DEPTH+1];
        int                     i;
        clk          = 1'b0;
        reset_b      = 1'b0;
        apb_req      = '0;
        drv_rx       = 1'b1;
        loopback     = 1'b1;
        seed         = 32'h6e19a589;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        entry_idx    = 0;
        cur_div      = `UART_DIV_RESET;
        repeat (8) @(posedge clk);
        reset_b <= 1'b1;
        @(posedge clk);

        begin_test();
        exp_st          = '0;
        exp_st.tx_empty = 1'b1;
        exp_st.rx_empty = 1'b1;
        read_status(act_st);
        compare_status("status after reset", exp_st, act_st);
        apb_read(`UART_ADDR_DIV, rd);
        compare_word("divisor after reset", 32'(`UART_DIV_RESET), rd);
        end_test("reset values");

        begin_test();
        for (i = 0; i < 4; i++)
            loop_bytes(4);                  // four per batch keeps both queues below full
        end_test("loopback at default divisor");

        begin_test();
        apb_write(`UART_ADDR_DIV, 32'd7);
        cur_div = 7;
        apb_read(`UART_ADDR_DIV, rd);
        compare_word("divisor of 7", 32'd7, rd);
        loop_bytes(4);
        apb_write(`UART_ADDR_DIV, 32'd2);
        apb_read(`UART_ADDR_DIV, rd);
        compare_word("clamped divisor", 32'(`UART_DIV_MIN), rd);
        apb_write(`UART_ADDR_DIV, 32'(`UART_DIV_RESET));
        cur_div = `UART_DIV_RESET;
        end_test("divisor");

        begin_test();
        @(posedge clk);
        loopback <= 1'b0;                   // rx now comes from the frame driver
        sent[0] = $random(seed);
        exp_q.push_back(expected_entry(sent[0], 1'b0));
        drive_frame(sent[0], 1'b0, cur_div);
        collect_entry();
        exp_st.frame_error = 1'b1;
        read_status(act_st);
        compare_status("status after bad stop bit", exp_st, act_st);
        mask             = '0;
        mask.frame_error = 1'b1;
        apb_write(`UART_ADDR_STATUS, 32'(mask));
        exp_st.frame_error = 1'b0;
        read_status(act_st);
        compare_status("status after frame error clear", exp_st, act_st);
        end_test("framing error");

        begin_test();
        for (i = 0; i <= `UART_FIFO_DEPTH; i++) begin
            sent[i] = $random(seed);
            drive_frame(sent[i], 1'b1, cur_div);
        end
        mask            = '0;
        mask.rx_overrun = 1'b1;
        poll_status("the overrun flag", mask, 1'b1);
        exp_st            = '0;
        exp_st.tx_empty   = 1'b1;
        exp_st.rx_overrun = 1'b1;
        read_status(act_st);
        compare_status("status with full receive queue", exp_st, act_st);
        for (i = 0; i < `UART_FIFO_DEPTH; i++) begin
            exp_q.push_back(expected_entry(sent[i], 1'b1));
            collect_entry();
        end
        exp_st.rx_empty = 1'b1;             // the ninth frame was dropped
        read_status(act_st);
        compare_status("status after draining", exp_st, act_st);
        apb_access(1'b0, `UART_ADDR_DATA, 32'h0, rd, slverr);
        compare_word("pslverr on empty data read", 32'd1, 32'(slverr));
        apb_access(1'b0, 4'hc, 32'h0, rd, slverr);
        compare_word("pslverr on read of 0xc", 32'd1, 32'(slverr));
        apb_access(1'b1, 4'hc, 32'h0, rd, slverr);
        compare_word("pslverr on write of 0xc", 32'd1, 32'(slverr));
        apb_write(`UART_ADDR_STATUS, 32'(mask));
        end_test("overrun and error responses");

        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected entries were never received", exp_q.size());
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+common
+incdir+sim
common/uart_pkg.sv
common/apb_pkg.sv
source/sync_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx_controller.sv
uart_rx/uart_rx_datapath.sv
source/uart_apb_regs.sv
source/uart_top.sv
sim/uart_tb.sv
